/* verilog/fifo_consts.svh */
// ********************
// FIFO_DEPTH must be a power of two, at least 4, and equal 2**FIFO_ADDR_W.
// FIFO_SYNC_STAGES below 2 stops elaboration of the top level.
// ********************
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

`define FIFO_DATA_W 32         // stored word width.

`define FIFO_DEPTH 16          // words, power of two.

`define FIFO_ADDR_W 4          // log2 of FIFO_DEPTH.

`define FIFO_SYNC_STAGES 2     // flip-flops per clock crossing.

`define FIFO_AFULL_MARGIN 2    // a_full when free space is at or below this.

`define FIFO_AEMPTY_MARGIN 2   // a_empty when stored words are at or below this.

`endif

/* verilog/fifo_pkg.sv */
// ********************
// Pointers carry one wrap bit above the address bits.
// ********************
`default_nettype none

`include "fifo_consts.svh"

package fifo_pkg;

    typedef logic [`FIFO_DATA_W-1:0] data_t;
    typedef logic [`FIFO_ADDR_W-1:0] addr_t;
    typedef logic [`FIFO_ADDR_W:0]   ptr_t;

    function automatic ptr_t bin2gray(input ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[`FIFO_ADDR_W] = gray[`FIFO_ADDR_W];
        for (int i = `FIFO_ADDR_W - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];  // fold from the msb down.
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

/* verilog/gray_sync.sv */
// ********************
// Only safe for gray-coded input, where one bit changes per source edge.
// Output lags the input by STAGES destination clock edges.
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module gray_sync #(
    parameter int STAGES = `FIFO_SYNC_STAGES
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  fifo_pkg::ptr_t gray_i,
    output fifo_pkg::ptr_t gray_o
);

    fifo_pkg::ptr_t sync_q [STAGES];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= gray_i;  // first flop may go metastable.
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign gray_o = sync_q[STAGES-1];

endmodule

`default_nettype wire

/* verilog/wr_ptr_full.sv */
// ********************
// A push while full_o is high is dropped.
// full_o and a_full_o clear only after a pop crosses the synchronizer.
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module wr_ptr_full (
    input  logic           wr_clk_i,
    input  logic           rst_n_i,
    input  logic           push_i,
    input  fifo_pkg::ptr_t wq_rgray_i,
    output logic           wr_en_o,
    output fifo_pkg::addr_t wr_addr_o,
    output fifo_pkg::ptr_t wr_gray_o,
    output logic           full_o,
    output logic           a_full_o
);

    fifo_pkg::ptr_t wr_bin_q;
    fifo_pkg::ptr_t wr_gray_q;
    fifo_pkg::ptr_t wr_bin_next;
    fifo_pkg::ptr_t wr_gray_next;
    fifo_pkg::ptr_t wq_rbin;
    fifo_pkg::ptr_t free_next;
    logic           accept;
    logic           full_q;
    logic           a_full_q;

    assign accept       = push_i & ~full_q;
    assign wr_bin_next  = wr_bin_q + fifo_pkg::ptr_t'(accept);
    assign wr_gray_next = fifo_pkg::bin2gray(wr_bin_next);
    assign wq_rbin      = fifo_pkg::gray2bin(wq_rgray_i);
    assign free_next    = fifo_pkg::ptr_t'(`FIFO_DEPTH) - (wr_bin_next - wq_rbin);

    always_ff @(posedge wr_clk_i) begin
        if (!rst_n_i) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
            full_q    <= 1'b0;
            a_full_q  <= 1'b0;
        end else begin
            wr_bin_q  <= wr_bin_next;
            wr_gray_q <= wr_gray_next;
            // full when the two top bits differ and the rest match.
            full_q    <= (wr_gray_next == {~wq_rgray_i[`FIFO_ADDR_W:`FIFO_ADDR_W-1],
                                           wq_rgray_i[`FIFO_ADDR_W-2:0]});
            a_full_q  <= (free_next <= fifo_pkg::ptr_t'(`FIFO_AFULL_MARGIN));
        end
    end

    assign wr_en_o   = accept;
    assign wr_addr_o = wr_bin_q[`FIFO_ADDR_W-1:0];  // wrap bit dropped.
    assign wr_gray_o = wr_gray_q;
    assign full_o    = full_q;
    assign a_full_o  = a_full_q;

endmodule

`default_nettype wire

/* verilog/rd_ptr_empty.sv */
// ********************
// A pop while empty_o is high is ignored.
// New words show up only after the write pointer crosses the synchronizer.
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module rd_ptr_empty (
    input  logic            rd_clk_i,
    input  logic            rst_n_i,
    input  logic            pop_i,
    input  fifo_pkg::ptr_t  rq_wgray_i,
    output fifo_pkg::addr_t rd_addr_o,
    output fifo_pkg::ptr_t  rd_gray_o,
    output logic            empty_o,
    output logic            a_empty_o
);

    fifo_pkg::ptr_t rd_bin_q;
    fifo_pkg::ptr_t rd_gray_q;
    fifo_pkg::ptr_t rd_bin_next;
    fifo_pkg::ptr_t rd_gray_next;
    fifo_pkg::ptr_t rq_wbin;
    fifo_pkg::ptr_t count_next;
    logic           accept;
    logic           empty_q;
    logic           a_empty_q;

    assign accept       = pop_i & ~empty_q;
    assign rd_bin_next  = rd_bin_q + fifo_pkg::ptr_t'(accept);
    assign rd_gray_next = fifo_pkg::bin2gray(rd_bin_next);
    assign rq_wbin      = fifo_pkg::gray2bin(rq_wgray_i);
    assign count_next   = rq_wbin - rd_bin_next;  // modulo the wrap bit.

    always_ff @(posedge rd_clk_i) begin
        if (!rst_n_i) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
            empty_q   <= 1'b1;
            a_empty_q <= 1'b1;
        end else begin
            rd_bin_q  <= rd_bin_next;
            rd_gray_q <= rd_gray_next;
            empty_q   <= (rd_gray_next == rq_wgray_i);
            a_empty_q <= (count_next <= fifo_pkg::ptr_t'(`FIFO_AEMPTY_MARGIN));
        end
    end

    // head of the FIFO, read straight from the memory.
    assign rd_addr_o = rd_bin_q[`FIFO_ADDR_W-1:0];
    assign rd_gray_o = rd_gray_q;
    assign empty_o   = empty_q;
    assign a_empty_o = a_empty_q;

endmodule

`default_nettype wire

/* verilog/ram_sdp.sv */
// ********************
// Write is clocked, read is combinational with no read enable.
// The array has no reset, so contents are unknown until written.
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module ram_sdp (
    input  logic            wr_clk_i,
    input  logic            wr_en_i,
    input  fifo_pkg::addr_t wr_addr_i,
    input  fifo_pkg::data_t wr_data_i,
    input  fifo_pkg::addr_t rd_addr_i,
    output fifo_pkg::data_t rd_data_o
);

    fifo_pkg::data_t mem [`FIFO_DEPTH];

    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // distributed-style read, so data follows the address at once.
    assign rd_data_o = mem[rd_addr_i];

endmodule

`default_nettype wire

/* verilog/async_fifo.sv */
// ********************
// No reset synchronizer. Hold rst_n_i low for 5 cycles of both clocks.
// Producer must watch full_o and consumer must watch empty_o.
// rd_data_o is valid only while empty_o is low.
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module async_fifo (
    input  logic            wr_clk_i,
    input  logic            push_i,
    input  fifo_pkg::data_t wr_data_i,

    input  logic            rd_clk_i,
    input  logic            pop_i,
    output fifo_pkg::data_t rd_data_o,

    input  logic            rst_n_i,

    output logic            full_o,
    output logic            a_full_o,
    output logic            empty_o,
    output logic            a_empty_o
);

    if (`FIFO_SYNC_STAGES < 2) begin : g_sync_stages_err
        $error("FIFO_SYNC_STAGES must be at least 2");
    end

    logic            mem_wr_en;
    fifo_pkg::addr_t mem_wr_addr;
    fifo_pkg::addr_t mem_rd_addr;
    fifo_pkg::ptr_t  wr_gray;
    fifo_pkg::ptr_t  rd_gray;
    fifo_pkg::ptr_t  rq_wgray;
    fifo_pkg::ptr_t  wq_rgray;

    wr_ptr_full i_wr_ptr_full (
        .wr_clk_i  (wr_clk_i),
        .rst_n_i   (rst_n_i),
        .push_i    (push_i),
        .wq_rgray_i(wq_rgray),
        .wr_en_o   (mem_wr_en),
        .wr_addr_o (mem_wr_addr),
        .wr_gray_o (wr_gray),
        .full_o    (full_o),
        .a_full_o  (a_full_o)
    );

    rd_ptr_empty i_rd_ptr_empty (
        .rd_clk_i  (rd_clk_i),
        .rst_n_i   (rst_n_i),
        .pop_i     (pop_i),
        .rq_wgray_i(rq_wgray),
        .rd_addr_o (mem_rd_addr),
        .rd_gray_o (rd_gray),
        .empty_o   (empty_o),
        .a_empty_o (a_empty_o)
    );

    ram_sdp i_ram_sdp (
        .wr_clk_i (wr_clk_i),
        .wr_en_i  (mem_wr_en),
        .wr_addr_i(mem_wr_addr),
        .wr_data_i(wr_data_i),
        .rd_addr_i(mem_rd_addr),
        .rd_data_o(rd_data_o)
    );

    // instance names follow the destination clock domain.
    gray_sync #(
        .STAGES(`FIFO_SYNC_STAGES)
    ) i_rd_sync (
        .clk_i  (rd_clk_i),
        .rst_n_i(rst_n_i),
        .gray_i (wr_gray),
        .gray_o (rq_wgray)
    );

    gray_sync #(
        .STAGES(`FIFO_SYNC_STAGES)
    ) i_wr_sync (
        .clk_i  (wr_clk_i),
        .rst_n_i(rst_n_i),
        .gray_i (rd_gray),
        .gray_o (wq_rgray)
    );

endmodule

`default_nettype wire

/* sim/async_fifo_asserts.sv */
// ********************
// Flag and pointer rules of async_fifo.
// Checks are off while rst_n_i is low.
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module async_fifo_asserts (
    input logic            wr_clk_i,
    input logic            rd_clk_i,
    input logic            rst_n_i,
    input logic            full_i,
    input logic            a_full_i,
    input logic            empty_i,
    input logic            a_empty_i,
    input logic            wr_en_i,
    input fifo_pkg::addr_t wr_addr_i,
    input fifo_pkg::addr_t rd_addr_i,
    input fifo_pkg::ptr_t  wr_gray_i,
    input fifo_pkg::ptr_t  rd_gray_i
);

    full_has_afull: assert property (@(posedge wr_clk_i) disable iff (!rst_n_i)
        full_i |-> a_full_i)
        else $error("full_o is high while a_full_o is low");

    empty_has_aempty: assert property (@(posedge rd_clk_i) disable iff (!rst_n_i)
        empty_i |-> a_empty_i)
        else $error("empty_o is high while a_empty_o is low");

    // same slot with different wrap bits means every slot holds unread data.
    no_write_when_full: assert property (@(posedge wr_clk_i) disable iff (!rst_n_i)
        wr_en_i |-> !(wr_addr_i == rd_addr_i
                      && wr_gray_i[`FIFO_ADDR_W] != rd_gray_i[`FIFO_ADDR_W]))
        else $error("memory written while every slot holds unread data");

    // equal pointers mean nothing is stored, so the read pointer must hold.
    rd_ptr_held_when_empty: assert property (@(posedge rd_clk_i) disable iff (!rst_n_i)
        (rd_gray_i == wr_gray_i) |=> $stable(rd_gray_i))
        else $error("read pointer moved while the FIFO was empty");

endmodule

`default_nettype wire

/* sim/async_fifo_tb.sv */
// ********************
// Flags are compared with the queue model only after both domains settle.
// Random data and gaps come from one seeded $random stream.
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module async_fifo_tb;

    localparam int MODE_INC      = 0;
    localparam int MODE_RAND     = 1;
    localparam int SETTLE_CYCLES = 8;

    logic            wr_clk = 1'b0;
    logic            rd_clk = 1'b0;
    logic            rst_n;
    logic            push;
    logic            pop;
    fifo_pkg::data_t wr_data;
    fifo_pkg::data_t rd_data;
    logic            full;
    logic            a_full;
    logic            empty;
    logic            a_empty;

    fifo_pkg::data_t model_q [$];
    fifo_pkg::data_t inc_word;
    integer          seed;
    int              checks;
    int              errors;
    logic            timed_out;
    string           cur_name;

    string row_name [$];
    int    row_push [$];
    int    row_pop [$];
    logic  row_overlap [$];
    int    row_mode [$];

    always #5 wr_clk = ~wr_clk;
    always #6.5 rd_clk = ~rd_clk;  // drifts against the write clock.

    async_fifo i_async_fifo (
        .wr_clk_i (wr_clk),
        .push_i   (push),
        .wr_data_i(wr_data),
        .rd_clk_i (rd_clk),
        .pop_i    (pop),
        .rd_data_o(rd_data),
        .rst_n_i  (rst_n),
        .full_o   (full),
        .a_full_o (a_full),
        .empty_o  (empty),
        .a_empty_o(a_empty)
    );

    bind async_fifo async_fifo_asserts i_async_fifo_asserts (
        .wr_clk_i (wr_clk_i),
        .rd_clk_i (rd_clk_i),
        .rst_n_i  (rst_n_i),
        .full_i   (full_o),
        .a_full_i (a_full_o),
        .empty_i  (empty_o),
        .a_empty_i(a_empty_o),
        .wr_en_i  (mem_wr_en),
        .wr_addr_i(mem_wr_addr),
        .rd_addr_i(mem_rd_addr),
        .wr_gray_i(wr_gray),
        .rd_gray_i(rd_gray)
    );

    task automatic add_row(input string name, input int n_push, input int n_pop,
                           input logic overlap, input int mode);
        row_name.push_back(name);
        row_push.push_back(n_push);
        row_pop.push_back(n_pop);
        row_overlap.push_back(overlap);
        row_mode.push_back(mode);
    endtask

    function automatic fifo_pkg::data_t make_word(input int mode);
        if (mode == MODE_RAND) begin
            return $random(seed);
        end
        inc_word = inc_word + 32'd1;
        return inc_word;
    endfunction

    task automatic check_word(input string what, input fifo_pkg::data_t exp,
                              input fifo_pkg::data_t act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s: %s expected %h actual %h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s: %s expected %b actual %b", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT in test %s: the %s did not finish in time", cur_name, what);
        timed_out = 1'b1;
    endtask

    task automatic check_flags();
        int count;
        count = model_q.size();
        check_flag("empty_o", count == 0, empty);
        check_flag("a_empty_o", count <= `FIFO_AEMPTY_MARGIN, a_empty);
        check_flag("full_o", count == `FIFO_DEPTH, full);
        check_flag("a_full_o", `FIFO_DEPTH - count <= `FIFO_AFULL_MARGIN, a_full);
    endtask

    task automatic settle();
        for (int i = 0; i < SETTLE_CYCLES; i++) begin
            @(posedge rd_clk);
        end
        #1;
    endtask

    // blind mode pushes n times and lets full_o drop words.
    task automatic push_words(input int n, input int mode, input logic obey);
        int              sent;
        int              tries;
        logic [31:0]     gap;
        fifo_pkg::data_t word;
        sent  = 0;
        tries = 0;
        while ((obey ? sent : tries) < n && !timed_out) begin
            @(posedge wr_clk);
            #1;
            gap  = $random(seed);
            push = !obey || (!full && gap[1:0] != 2'b00);
            if (push) begin
                word    = make_word(mode);
                wr_data = word;
                if (!full) begin
                    model_q.push_back(word);
                    sent++;
                end
            end
            tries++;
            if (tries > 20 * n + 100) report_timeout("write side waiting on full_o");
        end
        @(posedge wr_clk);
        #1;
        push = 1'b0;
    endtask

    task automatic pop_words(input int n, input logic obey);
        int          taken;
        int          tries;
        logic [31:0] gap;
        taken = 0;
        tries = 0;
        while ((obey ? taken : tries) < n && !timed_out) begin
            @(posedge rd_clk);
            #1;
            gap = $random(seed);
            pop = !obey || (!empty && gap[1:0] != 2'b00);
            if (pop && !empty) begin
                checks++;
                assert (model_q.size() > 0) else begin
                    $display("read side got a word that was never written in %s", cur_name);
                    errors++;
                end
                if (model_q.size() > 0) check_word("rd_data_o", model_q.pop_front(), rd_data);
                taken++;
            end
            tries++;
            if (tries > 20 * n + 100) report_timeout("read side waiting on empty_o");
        end
        @(posedge rd_clk);
        #1;
        pop = 1'b0;
    endtask

    task automatic run_row(input int r);
        int checks_start;
        int errors_start;
        checks_start = checks;
        errors_start = errors;
        cur_name     = row_name[r];
        check_flags();
        if (row_overlap[r]) begin
            fork
                push_words(row_push[r], row_mode[r], 1'b1);
                pop_words(row_pop[r], 1'b1);
            join
        end else begin
            push_words(row_push[r], row_mode[r], 1'b0);
            settle();
            check_flags();
            pop_words(row_pop[r], 1'b0);
        end
        settle();
        check_flags();
        $display("test %s: %0d checks, %0d errors", cur_name,
                 checks - checks_start, errors - errors_start);
    endtask

    initial begin
        rst_n     = 1'b0;
        push      = 1'b0;
        pop       = 1'b0;
        wr_data   = '0;
        seed      = 32'ha7ae_3638;
        inc_word  = 32'h0000_0100;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        // name, pushes, pops, overlap, data mode.
        add_row("reset_flags", 0, 0, 1'b0, MODE_INC);
        add_row("burst_order", 8, 8, 1'b0, MODE_INC);
        add_row("overflow", 19, 16, 1'b0, MODE_INC);
        add_row("underflow", 3, 7, 1'b0, MODE_INC);
        add_row("after_underflow", 5, 5, 1'b0, MODE_RAND);
        add_row("concurrent_random", 200, 200, 1'b1, MODE_RAND);
        add_row("almost_empty", 2, 0, 1'b0, MODE_INC);
        add_row("almost_empty_edge", 1, 0, 1'b0, MODE_INC);
        add_row("almost_full_edge", 10, 0, 1'b0, MODE_INC);
        add_row("almost_full", 1, 0, 1'b0, MODE_INC);
        add_row("drain", 0, 14, 1'b0, MODE_INC);
        fork
            repeat (5) @(posedge wr_clk);
            repeat (5) @(posedge rd_clk);
        join
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < row_name.size() && !timed_out; r++) begin
            run_row(r);
        end
        $display("tests %0d, checks %0d, errors %0d", row_name.size(), checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/fifo_pkg.sv
verilog/gray_sync.sv
verilog/wr_ptr_full.sv
verilog/rd_ptr_empty.sv
verilog/ram_sdp.sv
verilog/async_fifo.sv
sim/async_fifo_asserts.sv
sim/async_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the async FIFO testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module async_fifo_tb \
    -Mdir obj_dir -o async_fifo_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/async_fifo_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
